// File: project.f
src/video_pkg.sv
src/video_if.sv
src/raster_counter.sv
src/video_mode.sv
src/dram_fetch.sv
src/pixel_shifter.sv
src/video_top.sv
testbench/tb_video_top.sv

// File: run.sh
#!/bin/sh
# build the video fetch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_video_top -f project.f

out=$(./obj_dir/Vtb_video_top)
echo "$out"

# the exit status of grep decides pass or fail
echo "$out" | grep -q "^RESULT: PASS$"

// File: src/dram_fetch.sv
// DRAM fetch stage with a two entry request queue and word forwarding

`timescale 1ns/10ps

module dram_fetch (
    input  logic                         clk,
    input  logic                         arst_n,
    fetch_if.dst                         fch,
    output logic                         dram_req,
    output logic [video_pkg::ADDR_W-1:0] dram_addr,
    output video_pkg::bw_e               dram_bw,
    input  logic                         dram_ack,
    input  logic [video_pkg::DATA_W-1:0] dram_rdata,
    output logic                         word_valid,
    output logic [video_pkg::DATA_W-1:0] word_data,
    output video_pkg::bw_e               word_bw,
    output logic                         fetch_overrun
);
    import video_pkg::*;

    logic [ADDR_W-1:0] q_addr [2];
    bw_e               q_bw [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic              full;
    logic              push;
    logic              pop;

    assign full = count == 2'd2;
    assign push = fch.slot && !full;
    assign pop  = dram_req && dram_ack;

    // head of queue is what DRAM sees
    assign dram_req  = count != 2'd0;
    assign dram_addr = q_addr[rd_ptr];
    // idle bus shows the current frame's class
    assign dram_bw   = dram_req ? q_bw[rd_ptr] : fch.bw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= 1'b0;
            rd_ptr        <= 1'b0;
            count         <= 2'd0;
            fetch_overrun <= 1'b0;
            word_valid    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            // sticky until reset
            if (fch.slot && full) begin
                fetch_overrun <= 1'b1;
            end
            word_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_addr[wr_ptr] <= fch.addr;
            q_bw[wr_ptr]   <= fch.bw;
        end
        if (pop) begin
            word_data <= dram_rdata;
            word_bw   <= q_bw[rd_ptr];
        end
    end

    a_addr_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        dram_req && !dram_ack |=> dram_req && $stable(dram_addr))
        else $error("dram_fetch: request dropped or moved before acknowledge");

endmodule

// File: src/pixel_shifter.sv
// pixel shifter that unpacks DRAM words into pixel codes, one per clock

`timescale 1ns/10ps

module pixel_shifter (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         word_valid,
    input  logic [video_pkg::DATA_W-1:0] word_data,
    input  video_pkg::bw_e               word_bw,
    output logic [7:0]                   pix,
    output logic                         pix_valid
);
    import video_pkg::*;

    logic [DATA_W-1:0]        shreg;
    logic [DATA_W-1:0]        shreg_next;
    bw_e                      cur_bw;
    logic [$clog2(DATA_W):0]  left;
    logic [$clog2(DATA_W):0]  word_pix;

    // pixels per word
    always_comb begin
        case (word_bw)
            bw1:     word_pix = 5'd16;
            bw2:     word_pix = 5'd8;
            bw4:     word_pix = 5'd4;
            default: word_pix = 5'd2;
        endcase
    end

    // msb field out, then shift it away
    always_comb begin
        case (cur_bw)
            bw1: begin
                pix        = {7'b0, shreg[DATA_W-1]};
                shreg_next = shreg << 1;
            end
            bw2: begin
                pix        = {6'b0, shreg[DATA_W-1 -: 2]};
                shreg_next = shreg << 2;
            end
            bw4: begin
                pix        = {4'b0, shreg[DATA_W-1 -: 4]};
                shreg_next = shreg << 4;
            end
            default: begin
                pix        = shreg[DATA_W-1 -: 8];
                shreg_next = shreg << 8;
            end
        endcase
    end

    assign pix_valid = left != '0;

    // a new word overrides whatever is left of the old one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            left <= '0;
        end else if (word_valid) begin
            left <= word_pix;
        end else if (pix_valid) begin
            left <= left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            shreg  <= word_data;
            cur_bw <= word_bw;
        end else if (pix_valid) begin
            shreg <= shreg_next;
        end
    end

endmodule

// File: src/raster_counter.sv
// raster counter that scans columns and lines and marks line and frame starts

`timescale 1ns/10ps

module raster_counter (
    input  logic  clk,
    input  logic  arst_n,
    raster_if.src ras
);
    import video_pkg::*;

    logic [CNT_W-1:0] col;
    logic [CNT_W-1:0] row;
    logic             col_wrap;
    logic             row_wrap;
    logic             line_start_q;
    logic             frame_start_q;

    assign col_wrap = col == CNT_W'(H_TOTAL - 1);
    assign row_wrap = row == CNT_W'(V_TOTAL - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            if (col_wrap) begin
                col <= '0;
                if (row_wrap) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // pulses line up with column 0 of the new line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_start_q  <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            line_start_q  <= col_wrap;
            frame_start_q <= col_wrap && row_wrap;
        end
    end

    assign ras.cnt_col     = col;
    assign ras.cnt_row     = row;
    assign ras.line_start  = line_start_q;
    assign ras.frame_start = frame_start_q;

    a_col_range: assert property (
        @(posedge clk) disable iff (!arst_n) col < CNT_W'(H_TOTAL))
        else $error("raster_counter: column count reached H_TOTAL");

endmodule

// File: src/video_if.sv
// raster position and fetch slot interfaces between the video stages

`timescale 1ns/10ps

interface raster_if;
    import video_pkg::*;

    logic [CNT_W-1:0] cnt_col;
    logic [CNT_W-1:0] cnt_row;
    logic             line_start;
    logic             frame_start;

    modport src (output cnt_col, cnt_row, line_start, frame_start);
    modport dst (input cnt_col, cnt_row, line_start, frame_start);
endinterface

interface fetch_if;
    import video_pkg::*;

    logic              slot;
    logic [ADDR_W-1:0] addr;
    bw_e               bw;
    render_e           render;

    // no ready, slots are spaced by FETCH_STEP
    modport src (output slot, addr, bw, render);
    modport dst (input slot, addr, bw, render);
endinterface

// File: src/video_mode.sv
// video mode decoder with frame latched config, fetch window and slot addresses

`timescale 1ns/10ps

module video_mode (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [7:0]         vconfig,
    input  logic [7:0]         scr_page,
    raster_if.dst              ras,
    fetch_if.src               fch,
    output logic               hires,
    output video_pkg::render_e render_mode
);
    import video_pkg::*;

    mode_e             cfg_mode;
    rres_t             cfg_rres;
    logic [7:0]        cfg_page;
    logic              active;
    logic [CNT_W-1:0]  hpix_beg;
    logic [CNT_W-1:0]  hpix_end;
    logic [CNT_W-1:0]  vpix_beg;
    logic [CNT_W-1:0]  vpix_end;
    logic [CNT_W-1:0]  go_beg;
    logic [CNT_W-1:0]  go_end;
    logic [CNT_W-1:0]  col_ofs;
    logic [CNT_W-1:0]  win_row;
    logic              in_vwin;
    logic              hit;
    logic [7:0]        slot_idx;
    logic [21:0]       addr_gfx;
    logic [21:0]       addr_atr;
    logic [ADDR_W-1:0] addr_zx;
    logic [ADDR_W-1:0] addr_hc;
    logic              slot_q;
    logic [ADDR_W-1:0] addr_q;

    // config only moves at frame start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_mode <= zx;
            cfg_rres <= '0;
            cfg_page <= '0;
            active   <= 1'b0;
        end else if (ras.frame_start) begin
            cfg_mode <= mode_e'(vconfig[2:0]);
            cfg_rres <= vconfig[4:3];
            cfg_page <= scr_page;
            active   <= 1'b1;
        end
    end

    assign hpix_beg = HP_BEG[cfg_rres];
    assign hpix_end = HP_END[cfg_rres];
    assign vpix_beg = VP_BEG[cfg_rres];
    assign vpix_end = VP_END[cfg_rres];
    assign go_beg   = hpix_beg - GO_BEG_OFS[cfg_mode];
    assign go_end   = hpix_end - GO_END_OFS[cfg_mode];

    assign hires       = HIRES_MASK[cfg_mode];
    assign render_mode = RENDER_TBL[cfg_mode];

    // slot every FETCH_STEP columns inside the fetch window
    assign col_ofs = ras.cnt_col - go_beg;
    assign win_row = ras.cnt_row - vpix_beg;
    assign in_vwin = (ras.cnt_row >= vpix_beg) && (ras.cnt_row < vpix_end);
    assign hit     = active && in_vwin
                     && (ras.cnt_col >= go_beg) && (ras.cnt_col < go_end)
                     && ((col_ofs & CNT_W'(FETCH_STEP - 1)) == '0);

    // ZX screen, even slots fetch pixels, odd slots fetch attributes
    assign addr_gfx = {cfg_page, 1'b0, win_row[7:6], win_row[2:0], win_row[5:3],
                       slot_idx[4:0]};
    assign addr_atr = {cfg_page, 4'b0110, win_row[7:3], slot_idx[4:0]};
    assign addr_zx  = slot_idx[0] ? addr_atr[21:1] : addr_gfx[21:1];

    // 256c is linear
    assign addr_hc = {cfg_page[7:4], win_row, slot_idx};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_q   <= 1'b0;
            slot_idx <= '0;
        end else begin
            slot_q <= hit;
            if (ras.line_start) begin
                slot_idx <= '0;
            end else if (hit) begin
                slot_idx <= slot_idx + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            addr_q <= (cfg_mode == hc) ? addr_hc : addr_zx;
        end
    end

    assign fch.slot   = slot_q;
    assign fch.addr   = addr_q;
    assign fch.bw     = BW_TBL[cfg_mode];
    assign fch.render = render_mode;

    // dram_fetch has no ready and relies on this spacing
    a_slot_gap: assert property (
        @(posedge clk) disable iff (!arst_n) slot_q |=> !slot_q [*FETCH_STEP-1])
        else $error("video_mode: fetch slots closer than FETCH_STEP");

endmodule

// File: src/video_pkg.sv
// video fetch path package with mode encodings, raster tables and frame constants

package video_pkg;

    // frame geometry
    localparam int CNT_W      = 9;
    localparam int H_TOTAL    = 448;
    localparam int V_TOTAL    = 320;
    localparam int FETCH_STEP = 8;

    // DRAM word interface
    localparam int ADDR_W = 21;
    localparam int DATA_W = 16;

    // video mode, vconfig[2:0]
    typedef enum logic [2:0] {
        zx   = 3'd0,
        giga = 3'd1,
        m02  = 3'd2,
        m03  = 3'd3,
        m04  = 3'd4,
        m05  = 3'd5,
        hc   = 3'd6,
        text = 3'd7
    } mode_e;

    // raster resolution, vconfig[4:3]
    typedef logic [1:0] rres_t;

    // bits per pixel fetched from DRAM
    typedef enum logic [1:0] {
        bw1 = 2'b00,
        bw2 = 2'b01,
        bw4 = 2'b10,
        bw8 = 2'b11
    } bw_e;

    typedef enum logic [1:0] {
        r_zx = 2'h0,
        r_hc = 2'h1,
        r_02 = 2'h2,
        r_03 = 2'h3
    } render_e;

    // visible window per raster resolution
    localparam logic [CNT_W-1:0] HP_BEG [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
    localparam logic [CNT_W-1:0] HP_END [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
    localparam logic [CNT_W-1:0] VP_BEG [4] = '{9'd80, 9'd76, 9'd56, 9'd32};
    localparam logic [CNT_W-1:0] VP_END [4] = '{9'd272, 9'd276, 9'd296, 9'd320};

    // per mode decode, indexed by mode_e
    localparam bw_e BW_TBL [8] = '{bw1, bw2, bw2, bw4, bw8, bw2, bw4, bw4};
    localparam logic [7:0] HIRES_MASK = 8'b1010_0000;
    localparam render_e RENDER_TBL [8] = '{r_zx, r_zx, r_zx, r_zx, r_zx, r_zx, r_hc, r_zx};

    // fetch runs ahead of the visible window by these offsets
    localparam logic [CNT_W-1:0] GO_BEG_OFS [8] =
        '{9'd16, 9'd16, 9'd16, 9'd16, 9'd16, 9'd8, 9'd16, 9'd8};
    localparam logic [CNT_W-1:0] GO_END_OFS [8] =
        '{9'd18, 9'd18, 9'd18, 9'd18, 9'd18, 9'd10, 9'd18, 9'd10};

endpackage

// File: src/video_top.sv
// video fetch path top with raster, mode decode, DRAM fetch and pixel unpack

`timescale 1ns/10ps

module video_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [7:0]                   vconfig,
    input  logic [7:0]                   scr_page,
    output logic                         dram_req,
    output logic [video_pkg::ADDR_W-1:0] dram_addr,
    output video_pkg::bw_e               dram_bw,
    input  logic                         dram_ack,
    input  logic [video_pkg::DATA_W-1:0] dram_rdata,
    output logic [7:0]                   pix,
    output logic                         pix_valid,
    output logic                         hires,
    output video_pkg::render_e           render_mode,
    output logic                         frame_start,
    output logic                         fetch_overrun
);
    import video_pkg::*;

    logic              word_valid;
    logic [DATA_W-1:0] word_data;
    bw_e               word_bw;

    raster_if ras ();
    fetch_if  fch ();

    raster_counter raster_counter_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ras    (ras)
    );

    video_mode video_mode_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .vconfig     (vconfig),
        .scr_page    (scr_page),
        .ras         (ras),
        .fch         (fch),
        .hires       (hires),
        .render_mode (render_mode)
    );

    dram_fetch dram_fetch_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .fch           (fch),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .dram_bw       (dram_bw),
        .dram_ack      (dram_ack),
        .dram_rdata    (dram_rdata),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .word_bw       (word_bw),
        .fetch_overrun (fetch_overrun)
    );

    pixel_shifter pixel_shifter_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_bw    (word_bw),
        .pix        (pix),
        .pix_valid  (pix_valid)
    );

    assign frame_start = ras.frame_start;

endmodule

// File: testbench/tb_video_top.sv
// testbench for the video fetch path with a DRAM model, a mode table and pixel checks

`timescale 1ns/10ps

module tb_video_top;
    import video_pkg::*;

    typedef struct packed {
        logic [7:0] vconfig;
        logic [7:0] page;
        logic       hires;
        logic [1:0] render;
        logic [1:0] bw;
        logic [7:0] slots;
    } entry_t;

    localparam int N_ENTRIES = 5;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL + 16;

    logic              clk;
    logic              arst_n;
    logic [7:0]        vconfig;
    logic [7:0]        scr_page;
    logic              dram_req;
    logic [ADDR_W-1:0] dram_addr;
    bw_e               dram_bw;
    logic              dram_ack = 1'b0;
    logic [DATA_W-1:0] dram_rdata = '0;
    logic [7:0]        pix;
    logic              pix_valid;
    logic              hires;
    render_e           render_mode;
    logic              frame_start;
    logic              fetch_overrun;

    entry_t tbl [N_ENTRIES];
    int     err_main = 0;
    int     err_mon = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    bit     timed_out = 1'b0;
    bit     mon_en = 1'b0;
    bw_e    cur_bw = bw1;

    // outputs sampled at the falling edge
    logic              s_req = 1'b0;
    logic [ADDR_W-1:0] s_addr = '0;
    logic [1:0]        s_bw;
    logic [7:0]        s_pix;
    logic              s_pix_valid;
    logic              s_hires;
    logic [1:0]        s_render;
    logic              s_frame = 1'b0;
    logic              s_ovr;

    // the first cycle out of reset sits at the frame origin
    int                frame_gap = -1;

    // DRAM model state
    logic              pending = 1'b0;
    logic [2:0]        wait_cnt = 3'd0;
    logic [ADDR_W-1:0] held_addr = '0;
    logic [31:0]       rng = 32'h70c833ef;
    logic [ADDR_W-1:0] acc_addr [$];

    // expected pixel stream with words landing two cycles after the accept
    bit          d1_vld = 1'b0;
    bit          d2_vld = 1'b0;
    logic [15:0] d1_data;
    logic [15:0] d2_data;
    int          d1_bw;
    int          d2_bw;
    logic [15:0] exp_sh;
    int          exp_bw = 0;
    int          exp_left = 0;
    logic [7:0]  fld;

    video_top video_top_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .vconfig       (vconfig),
        .scr_page      (scr_page),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .dram_bw       (dram_bw),
        .dram_ack      (dram_ack),
        .dram_rdata    (dram_rdata),
        .pix           (pix),
        .pix_valid     (pix_valid),
        .hires         (hires),
        .render_mode   (render_mode),
        .frame_start   (frame_start),
        .fetch_overrun (fetch_overrun)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void show_mismatch(input string name, input logic [31:0] expv,
                                          input logic [31:0] actv);
        $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, expv, actv);
    endfunction

    // word address of slot k on the first window line
    function automatic logic [ADDR_W-1:0] slot_addr(input entry_t e, input int k);
        logic [21:0] byte_addr;
        int          col;
        col = k % 32;
        if (e.vconfig[2:0] == 3'd6) begin
            return ADDR_W'((int'(e.page[7:4]) << 17) + (k % 256));
        end
        // ZX screen with pixels at offset 0 and attributes at 0x1800
        byte_addr = (22'(e.page) << 14) + 22'(col);
        if (k % 2 == 1) begin
            byte_addr = byte_addr + 22'd6144;
        end
        return byte_addr[21:1];
    endfunction

    function automatic int check_flags(input entry_t e);
        int bad;
        bad = 0;
        if (s_hires != e.hires) begin
            show_mismatch("hires", 32'(e.hires), 32'(s_hires));
            bad++;
        end
        if (s_render != e.render) begin
            show_mismatch("render_mode", 32'(e.render), 32'(s_render));
            bad++;
        end
        if (s_bw != e.bw) begin
            show_mismatch("dram_bw", 32'(e.bw), 32'(s_bw));
            bad++;
        end
        return bad;
    endfunction

    task automatic load_table();
        // vconfig, page, hires, render, bw, slots per line
        tbl[0] = '{8'h00, 8'h05, 1'b0, r_zx, bw1, 8'd32};
        tbl[1] = '{8'h0e, 8'ha3, 1'b0, r_hc, bw4, 8'd40};
        tbl[2] = '{8'h1f, 8'h40, 1'b1, r_zx, bw4, 8'd45};
        tbl[3] = '{8'h14, 8'h11, 1'b0, r_zx, bw8, 8'd40};
        tbl[4] = '{8'h05, 8'h2c, 1'b1, r_zx, bw2, 8'd32};
    endtask

    // mode 0 checks that the DUT is idle, mode 1 that the flags hold
    task automatic wait_frame(input int mode, input entry_t e);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (mode == 0 && (s_req || s_pix_valid || s_ovr)) begin
                $display("t=%0t DUT active before the first frame", $time);
                err_main++;
            end else if (mode == 1) begin
                err_main += check_flags(e);
            end
        end while (!s_frame && n < FRAME_CYC);
        if (!s_frame) begin
            $display("t=%0t timeout, no frame_start within a frame period", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        int errs;
        errs = err_main + err_mon - err_start;
        tests_run++;
        if (errs != 0 || timed_out) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errs);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // DRAM model that acknowledges 1 to 4 cycles after it sees a request
    always @(posedge clk) begin
        if (!arst_n || dram_ack) begin
            dram_ack <= 1'b0;
            pending  <= 1'b0;
        end else if (s_req && !pending) begin
            rng       <= xorshift32(rng);
            wait_cnt  <= 3'(rng[1:0]) + 3'd1;
            held_addr <= s_addr;
            pending   <= 1'b1;
        end else if (pending) begin
            if (wait_cnt == 3'd1) begin
                dram_ack   <= 1'b1;
                dram_rdata <= held_addr[15:0] ^ 16'h5a3c;
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end
    end

    always @(negedge clk) begin
        s_req       = dram_req;
        s_addr      = dram_addr;
        s_bw        = dram_bw;
        s_pix       = pix;
        s_pix_valid = pix_valid;
        s_hires     = hires;
        s_render    = render_mode;
        s_frame     = frame_start;
        s_ovr       = fetch_overrun;
        if (mon_en) begin
            frame_gap++;
            if (s_frame) begin
                if (frame_gap != H_TOTAL * V_TOTAL) begin
                    show_mismatch("frame_start period", 32'(H_TOTAL * V_TOTAL),
                                  32'(frame_gap));
                    err_mon++;
                end
                frame_gap = 0;
            end
            if (pending && !s_req) begin
                $display("t=%0t dram_req fell before its acknowledge", $time);
                err_mon++;
            end else if (pending && s_addr != held_addr) begin
                show_mismatch("dram_addr", 32'(held_addr), 32'(s_addr));
                err_mon++;
            end
            if (d2_vld) begin
                exp_sh   = d2_data;
                exp_bw   = d2_bw;
                exp_left = 16 >> d2_bw;
            end else if (exp_left > 0) begin
                exp_sh = exp_sh << (1 << exp_bw);
                exp_left--;
            end
            fld = 8'(exp_sh >> (16 - (1 << exp_bw)));
            if (s_pix_valid != (exp_left > 0)) begin
                show_mismatch("pix_valid", 32'(exp_left > 0), 32'(s_pix_valid));
                err_mon++;
            end else if (exp_left > 0 && s_pix != fld) begin
                show_mismatch("pix", 32'(fld), 32'(s_pix));
                err_mon++;
            end
            d2_vld  = d1_vld;
            d2_data = d1_data;
            d2_bw   = d1_bw;
            d1_vld  = s_req && dram_ack;
            d1_data = dram_rdata;
            d1_bw   = int'(cur_bw);
            if (d1_vld) begin
                acc_addr.push_back(s_addr);
            end
        end
    end

    initial begin
        int     i;
        int     k;
        int     n;
        int     base;
        int     seen;
        int     idle;
        int     err_start;
        entry_t e;
        entry_t next_e;

        load_table();
        arst_n   <= 1'b0;
        vconfig  <= tbl[0].vconfig;
        scr_page <= tbl[0].page;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        mon_en = 1'b1;

        err_start = err_main + err_mon;
        wait_frame(0, tbl[0]);
        finish_test("reset", err_start);

        for (i = 0; i < N_ENTRIES && !timed_out; i++) begin
            e         = tbl[i];
            next_e    = tbl[(i + 1) % N_ENTRIES];
            err_start = err_main + err_mon;
            cur_bw    = bw_e'(e.bw);
            // flags follow the latched config one cycle after frame_start
            @(posedge clk);
            err_main += check_flags(e);

            base = acc_addr.size();
            n    = 0;
            while (acc_addr.size() == base && n < FRAME_CYC) begin
                @(posedge clk);
                n++;
            end
            if (acc_addr.size() == base) begin
                $display("t=%0t timeout, no DRAM request in the frame", $time);
                timed_out = 1'b1;
            end else begin
                // line is over once requests pause for a few slot periods
                seen = acc_addr.size();
                idle = 0;
                n    = 0;
                while (idle < 3 * FETCH_STEP && n < H_TOTAL) begin
                    @(posedge clk);
                    n++;
                    if (acc_addr.size() != seen) begin
                        seen = acc_addr.size();
                        idle = 0;
                    end else begin
                        idle++;
                    end
                end
                if (idle < 3 * FETCH_STEP) begin
                    $display("t=%0t requests did not pause within a line", $time);
                    err_main++;
                end
                if (seen - base != int'(e.slots)) begin
                    show_mismatch("slots per line", 32'(e.slots), 32'(seen - base));
                    err_main++;
                end
                for (k = 0; k < seen - base && k < int'(e.slots); k++) begin
                    if (acc_addr[base + k] != slot_addr(e, k)) begin
                        show_mismatch("dram_addr", 32'(slot_addr(e, k)),
                                      32'(acc_addr[base + k]));
                        err_main++;
                    end
                end
                if (s_ovr) begin
                    show_mismatch("fetch_overrun", 32'd0, 32'(s_ovr));
                    err_main++;
                end
                // next mode arrives mid frame and must wait for frame_start
                vconfig  <= next_e.vconfig;
                scr_page <= next_e.page;
                wait_frame(1, e);
            end
            finish_test($sformatf("vconfig %02h", e.vconfig), err_start);
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 err_main + err_mon);
        if (timed_out || tests_failed != 0 || err_main + err_mon != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule
